// File: src/cfg_pkg.sv
// Shared AXI4-Lite types and fabric constants; addresses and data are 32 bits, map is fixed
package cfg_pkg;

  localparam int unsigned NumMgr      = 2;
  localparam int unsigned NumSub      = 3;
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned NumRules    = 4;
  // Cycles to wait for a B or R once the address phase is over
  localparam int unsigned RespTimeout = 64;
  localparam int unsigned TimerWidth  = $clog2(RespTimeout);

  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [DataWidth/8-1:0]   strb_t;
  typedef logic [$clog2(NumMgr)-1:0] mgr_idx_t;
  typedef logic [$clog2(NumSub)-1:0] sub_idx_t;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } aw_chan_t;

  typedef struct packed {
    addr_t      addr;
    logic [2:0] prot;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  typedef struct packed {
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    resp_e resp;
  } r_chan_t;

  // Manager-driven half of an AXI4-Lite port
  typedef struct packed {
    logic     aw_valid;
    aw_chan_t aw;
    logic     w_valid;
    w_chan_t  w;
    logic     b_ready;
    logic     ar_valid;
    ar_chan_t ar;
    logic     r_ready;
  } lite_req_t;

  // Subordinate-driven half of an AXI4-Lite port
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    logic    b_valid;
    b_chan_t b;
    logic    ar_ready;
    logic    r_valid;
    r_chan_t r;
  } lite_resp_t;

  typedef struct packed {
    sub_idx_t idx;
    addr_t    start_addr;
    addr_t    end_addr;
  } map_rule_t;

  // End addresses are exclusive; two windows share the cluster-to-host TLB
  localparam map_rule_t [NumRules-1:0] AddrMap = '{
    '{idx: 2'd2, start_addr: 32'h1040_3000, end_addr: 32'h1040_4000},
    '{idx: 2'd1, start_addr: 32'h1040_2000, end_addr: 32'h1040_3000},
    '{idx: 2'd1, start_addr: 32'h1040_1000, end_addr: 32'h1040_2000},
    '{idx: 2'd0, start_addr: 32'h1040_0000, end_addr: 32'h1040_1000}
  };

  // Per-cycle steering decision from the FSM to the route mux
  typedef struct packed {
    mgr_idx_t          mgr;
    sub_idx_t          sub;
    logic              write;
    logic              aw_en;
    logic              w_en;
    logic              ar_en;
    logic              rsp_en;
    logic              local_valid;
    resp_e             local_resp;
    logic              capture;
    logic [NumSub-1:0] dead;
  } route_t;

  typedef struct packed {
    logic aw_fire;
    logic w_fire;
    logic ar_fire;
    logic sub_rsp_fire;
    logic mgr_rsp_fire;
  } xfer_evt_t;

endpackage

// File: src/cfg_chan_reg.sv
// Holds at most two payloads; ready_o drops only when both slots are occupied
module cfg_chan_reg #(
  parameter type chan_t = logic
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  valid_i,
  input  chan_t data_i,
  output logic  ready_o,
  output logic  valid_o,
  output chan_t data_o,
  input  logic  ready_i
);

  logic  a_full_q, b_full_q;
  chan_t a_data_q, b_data_q;
  logic  in_fire, out_fire;

  assign ready_o  = !b_full_q;
  assign valid_o  = a_full_q;
  assign data_o   = a_data_q;
  assign in_fire  = valid_i && ready_o;
  assign out_fire = a_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (out_fire) begin
      // Slot B refills the head first; it cannot take input while full
      if (b_full_q) begin
        b_full_q <= 1'b0;
      end else if (!in_fire) begin
        a_full_q <= 1'b0;
      end
    end else if (in_fire) begin
      if (!a_full_q) begin
        a_full_q <= 1'b1;
      end else begin
        b_full_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_fire && b_full_q) begin
      a_data_q <= b_data_q;
    end else if (in_fire && (!a_full_q || out_fire)) begin
      a_data_q <= data_i;
    end else if (in_fire) begin
      b_data_q <= data_i;
    end
  end

  a_head_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

// File: src/cfg_resp_timer.sv
// One timer for the whole fabric; start_i is only legal while no count is running
module cfg_resp_timer
  import cfg_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic clear_i,
  output logic expired_o
);

  logic [TimerWidth-1:0] cnt_q;
  logic                  running_q;
  logic                  expired_q;

  assign expired_o = expired_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q     <= '0;
      running_q <= 1'b0;
      expired_q <= 1'b0;
    end else begin
      expired_q <= 1'b0;
      if (start_i) begin
        cnt_q     <= '0;
        running_q <= 1'b1;
      end else if (clear_i) begin
        running_q <= 1'b0;
      end else if (running_q) begin
        // Pulse lands RespTimeout cycles after the start
        if (cnt_q == TimerWidth'(RespTimeout - 1)) begin
          running_q <= 1'b0;
          expired_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  no_restart: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_i |-> !running_q);

endmodule

// File: src/cfg_xbar_fsm.sv
// Serves one transaction at a time; a subordinate marked dead stays dead until reset
module cfg_xbar_fsm
  import cfg_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  aw_chan_t [NumMgr-1:0] head_aw_i,
  input  ar_chan_t [NumMgr-1:0] head_ar_i,
  input  logic [NumMgr-1:0]     aw_pending_i,
  input  logic [NumMgr-1:0]     w_pending_i,
  input  logic [NumMgr-1:0]     ar_pending_i,
  input  xfer_evt_t             evt_i,
  input  logic                  timer_expired_i,
  output route_t                route_o,
  output logic                  timer_start_o,
  output logic                  timer_clear_o
);

  typedef enum logic [2:0] {
    IDLE,
    WRITE_ADDR,
    READ_ADDR,
    WAIT_RESP,
    RESP_OUT
  } state_e;

  state_e            state_q, state_d;
  mgr_idx_t          mgr_q, mgr_d;
  sub_idx_t          sub_q, sub_d;
  logic              write_q, write_d;
  logic              aw_done_q, aw_done_d;
  logic              w_done_q, w_done_d;
  logic [1:0]        last_q, last_d;
  logic [NumSub-1:0] dead_q, dead_d;

  logic [3:0] src_req;
  logic [1:0] sel_src;
  logic       found;
  mgr_idx_t   sel_mgr;
  logic       sel_write;
  addr_t      sel_addr;
  logic       dec_hit;
  sub_idx_t   dec_idx;

  // Sources are numbered {manager, is_read}; rotation starts after the last one served
  always_comb begin
    logic [1:0] cand;
    for (int unsigned m = 0; m < NumMgr; m++) begin
      src_req[2*m]   = aw_pending_i[m] && w_pending_i[m];
      src_req[2*m+1] = ar_pending_i[m];
    end
    found   = 1'b0;
    sel_src = last_q;
    for (int unsigned k = 1; k <= 4; k++) begin
      cand = last_q + 2'(k);
      if (!found && src_req[cand]) begin
        found   = 1'b1;
        sel_src = cand;
      end
    end
    sel_mgr   = mgr_idx_t'(sel_src[1]);
    sel_write = !sel_src[0];
    sel_addr  = sel_write ? head_aw_i[sel_mgr].addr : head_ar_i[sel_mgr].addr;
    dec_hit   = 1'b0;
    dec_idx   = '0;
    for (int unsigned r = 0; r < NumRules; r++) begin
      if (sel_addr >= AddrMap[r].start_addr && sel_addr < AddrMap[r].end_addr) begin
        dec_hit = 1'b1;
        dec_idx = AddrMap[r].idx;
      end
    end
  end

  always_comb begin
    state_d   = state_q;
    mgr_d     = mgr_q;
    sub_d     = sub_q;
    write_d   = write_q;
    aw_done_d = aw_done_q;
    w_done_d  = w_done_q;
    last_d    = last_q;
    dead_d    = dead_q;

    route_o       = '0;
    route_o.mgr   = mgr_q;
    route_o.sub   = sub_q;
    route_o.write = write_q;
    route_o.dead  = dead_q;
    timer_start_o = 1'b0;
    timer_clear_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (found) begin
          route_o.mgr   = sel_mgr;
          route_o.write = sel_write;
          route_o.sub   = dec_idx;
          mgr_d         = sel_mgr;
          write_d       = sel_write;
          sub_d         = dec_idx;
          last_d        = sel_src;
          if (!dec_hit || dead_q[dec_idx]) begin
            // Retire the request locally; the mux drops the heads instead of forwarding
            route_o.local_valid = 1'b1;
            route_o.local_resp  = dec_hit ? RESP_SLVERR : RESP_DECERR;
            route_o.capture     = 1'b1;
            route_o.aw_en       = sel_write;
            route_o.w_en        = sel_write;
            route_o.ar_en       = !sel_write;
            state_d             = RESP_OUT;
          end else begin
            state_d = sel_write ? WRITE_ADDR : READ_ADDR;
          end
        end
      end
      WRITE_ADDR: begin
        route_o.aw_en = !aw_done_q;
        route_o.w_en  = !w_done_q;
        aw_done_d     = aw_done_q || evt_i.aw_fire;
        w_done_d      = w_done_q || evt_i.w_fire;
        if (aw_done_d && w_done_d) begin
          aw_done_d     = 1'b0;
          w_done_d      = 1'b0;
          timer_start_o = 1'b1;
          state_d       = WAIT_RESP;
        end
      end
      READ_ADDR: begin
        route_o.ar_en = 1'b1;
        if (evt_i.ar_fire) begin
          timer_start_o = 1'b1;
          state_d       = WAIT_RESP;
        end
      end
      WAIT_RESP: begin
        route_o.capture = 1'b1;
        if (timer_expired_i) begin
          route_o.local_valid = 1'b1;
          route_o.local_resp  = RESP_SLVERR;
          dead_d[sub_q]       = 1'b1;
          state_d             = RESP_OUT;
        end else begin
          route_o.rsp_en = 1'b1;
          if (evt_i.sub_rsp_fire) begin
            timer_clear_o = 1'b1;
            state_d       = RESP_OUT;
          end
        end
      end
      RESP_OUT: begin
        if (evt_i.mgr_rsp_fire) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      mgr_q     <= '0;
      sub_q     <= '0;
      write_q   <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      last_q    <= 2'd3;
      dead_q    <= '0;
    end else begin
      state_q   <= state_d;
      mgr_q     <= mgr_d;
      sub_q     <= sub_d;
      write_q   <= write_d;
      aw_done_q <= aw_done_d;
      w_done_q  <= w_done_d;
      last_q    <= last_d;
      dead_q    <= dead_d;
    end
  end

  mgr_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    state_q != IDLE |=> state_q == IDLE || $stable(route_o.mgr));

  local_excl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    route_o.local_valid |-> !route_o.rsp_en && !evt_i.sub_rsp_fire);

endmodule

// File: src/cfg_route_mux.sv
// Steers one manager to one subordinate; the response register shows one B or R at a time
module cfg_route_mux
  import cfg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [NumMgr-1:0]       aw_valid_i,
  input  aw_chan_t [NumMgr-1:0]   aw_i,
  input  logic [NumMgr-1:0]       w_valid_i,
  input  w_chan_t [NumMgr-1:0]    w_i,
  input  logic [NumMgr-1:0]       ar_valid_i,
  input  ar_chan_t [NumMgr-1:0]   ar_i,
  input  logic [NumMgr-1:0]       mgr_bready_i,
  input  logic [NumMgr-1:0]       mgr_rready_i,
  input  route_t                  route_i,
  input  lite_resp_t [NumSub-1:0] sub_resp_i,
  output logic [NumMgr-1:0]       aw_pop_o,
  output logic [NumMgr-1:0]       w_pop_o,
  output logic [NumMgr-1:0]       ar_pop_o,
  output lite_req_t [NumSub-1:0]  sub_req_o,
  output b_chan_t                 mgr_b_o,
  output logic [NumMgr-1:0]       mgr_bvalid_o,
  output r_chan_t                 mgr_r_o,
  output logic [NumMgr-1:0]       mgr_rvalid_o,
  output xfer_evt_t               evt_o,
  output logic [NumMgr-1:0]       aw_pending_o,
  output logic [NumMgr-1:0]       w_pending_o,
  output logic [NumMgr-1:0]       ar_pending_o
);

  logic    hold_valid_q;
  r_chan_t hold_q;
  logic    sub_rsp_valid;
  logic    load_local, load_sub;

  assign aw_pending_o = aw_valid_i;
  assign w_pending_o  = w_valid_i;
  assign ar_pending_o = ar_valid_i;

  always_comb begin
    sub_rsp_valid = route_i.write ? sub_resp_i[route_i.sub].b_valid
                                  : sub_resp_i[route_i.sub].r_valid;
    // With a local response the heads are dropped without waiting on a subordinate
    evt_o.aw_fire = route_i.aw_en && aw_valid_i[route_i.mgr] &&
                    (route_i.local_valid || sub_resp_i[route_i.sub].aw_ready);
    evt_o.w_fire  = route_i.w_en && w_valid_i[route_i.mgr] &&
                    (route_i.local_valid || sub_resp_i[route_i.sub].w_ready);
    evt_o.ar_fire = route_i.ar_en && ar_valid_i[route_i.mgr] &&
                    (route_i.local_valid || sub_resp_i[route_i.sub].ar_ready);
    evt_o.sub_rsp_fire = route_i.rsp_en && sub_rsp_valid;
    evt_o.mgr_rsp_fire = hold_valid_q && (route_i.write ? mgr_bready_i[route_i.mgr]
                                                        : mgr_rready_i[route_i.mgr]);
  end

  always_comb begin
    for (int unsigned m = 0; m < NumMgr; m++) begin
      aw_pop_o[m]     = evt_o.aw_fire && (route_i.mgr == mgr_idx_t'(m));
      w_pop_o[m]      = evt_o.w_fire && (route_i.mgr == mgr_idx_t'(m));
      ar_pop_o[m]     = evt_o.ar_fire && (route_i.mgr == mgr_idx_t'(m));
      mgr_bvalid_o[m] = hold_valid_q && route_i.write && (route_i.mgr == mgr_idx_t'(m));
      mgr_rvalid_o[m] = hold_valid_q && !route_i.write && (route_i.mgr == mgr_idx_t'(m));
    end
  end

  always_comb begin
    for (int unsigned s = 0; s < NumSub; s++) begin
      sub_req_o[s]    = '0;
      sub_req_o[s].aw = aw_i[route_i.mgr];
      sub_req_o[s].w  = w_i[route_i.mgr];
      sub_req_o[s].ar = ar_i[route_i.mgr];
      if (route_i.sub == sub_idx_t'(s) && !route_i.local_valid) begin
        sub_req_o[s].aw_valid = route_i.aw_en && aw_valid_i[route_i.mgr];
        sub_req_o[s].w_valid  = route_i.w_en && w_valid_i[route_i.mgr];
        sub_req_o[s].ar_valid = route_i.ar_en && ar_valid_i[route_i.mgr];
        sub_req_o[s].b_ready  = route_i.rsp_en && route_i.write;
        sub_req_o[s].r_ready  = route_i.rsp_en && !route_i.write;
      end
      // A timed-out subordinate may still answer later, so it is always drained
      if (route_i.dead[s]) begin
        sub_req_o[s].b_ready = 1'b1;
        sub_req_o[s].r_ready = 1'b1;
      end
    end
  end

  assign load_local = route_i.capture && route_i.local_valid;
  assign load_sub   = route_i.capture && evt_o.sub_rsp_fire;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_valid_q <= 1'b0;
    end else if (load_local || load_sub) begin
      hold_valid_q <= 1'b1;
    end else if (evt_o.mgr_rsp_fire) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_local) begin
      hold_q.data <= '0;
      hold_q.resp <= route_i.local_resp;
    end else if (load_sub && route_i.write) begin
      hold_q.data <= '0;
      hold_q.resp <= sub_resp_i[route_i.sub].b.resp;
    end else if (load_sub) begin
      hold_q <= sub_resp_i[route_i.sub].r;
    end
  end

  assign mgr_b_o.resp = hold_q.resp;
  assign mgr_r_o      = hold_q;

endmodule

// File: src/cfg_lite_subsystem.sv
// Two AXI4-Lite managers to three config subordinates, one transaction in flight at a time
module cfg_lite_subsystem
  import cfg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  lite_req_t [NumMgr-1:0]  mgr_req_i,
  output lite_resp_t [NumMgr-1:0] mgr_resp_o,
  output lite_req_t [NumSub-1:0]  sub_req_o,
  input  lite_resp_t [NumSub-1:0] sub_resp_i
);

  logic [NumMgr-1:0]     aw_head_valid, w_head_valid, ar_head_valid;
  aw_chan_t [NumMgr-1:0] aw_head;
  w_chan_t [NumMgr-1:0]  w_head;
  ar_chan_t [NumMgr-1:0] ar_head;
  logic [NumMgr-1:0]     aw_pop, w_pop, ar_pop;
  logic [NumMgr-1:0]     aw_pending, w_pending, ar_pending;
  logic [NumMgr-1:0]     mgr_bready, mgr_rready;
  logic [NumMgr-1:0]     mgr_bvalid, mgr_rvalid;
  b_chan_t               mgr_b;
  r_chan_t               mgr_r;
  route_t                route;
  xfer_evt_t             evt;
  logic                  timer_start, timer_clear, timer_expired;

  for (genvar m = 0; m < NumMgr; m++) begin : g_mgr
    cfg_chan_reg #(.chan_t(aw_chan_t)) i_aw_cut (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (mgr_req_i[m].aw_valid),
      .data_i   (mgr_req_i[m].aw),
      .ready_o  (mgr_resp_o[m].aw_ready),
      .valid_o  (aw_head_valid[m]),
      .data_o   (aw_head[m]),
      .ready_i  (aw_pop[m])
    );

    cfg_chan_reg #(.chan_t(w_chan_t)) i_w_cut (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (mgr_req_i[m].w_valid),
      .data_i   (mgr_req_i[m].w),
      .ready_o  (mgr_resp_o[m].w_ready),
      .valid_o  (w_head_valid[m]),
      .data_o   (w_head[m]),
      .ready_i  (w_pop[m])
    );

    cfg_chan_reg #(.chan_t(ar_chan_t)) i_ar_cut (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (mgr_req_i[m].ar_valid),
      .data_i   (mgr_req_i[m].ar),
      .ready_o  (mgr_resp_o[m].ar_ready),
      .valid_o  (ar_head_valid[m]),
      .data_o   (ar_head[m]),
      .ready_i  (ar_pop[m])
    );

    assign mgr_bready[m]         = mgr_req_i[m].b_ready;
    assign mgr_rready[m]         = mgr_req_i[m].r_ready;
    assign mgr_resp_o[m].b_valid = mgr_bvalid[m];
    assign mgr_resp_o[m].b       = mgr_b;
    assign mgr_resp_o[m].r_valid = mgr_rvalid[m];
    assign mgr_resp_o[m].r       = mgr_r;
  end

  cfg_xbar_fsm i_fsm (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .head_aw_i       (aw_head),
    .head_ar_i       (ar_head),
    .aw_pending_i    (aw_pending),
    .w_pending_i     (w_pending),
    .ar_pending_i    (ar_pending),
    .evt_i           (evt),
    .timer_expired_i (timer_expired),
    .route_o         (route),
    .timer_start_o   (timer_start),
    .timer_clear_o   (timer_clear)
  );

  cfg_resp_timer i_timer (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .start_i   (timer_start),
    .clear_i   (timer_clear),
    .expired_o (timer_expired)
  );

  cfg_route_mux i_mux (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .aw_valid_i   (aw_head_valid),
    .aw_i         (aw_head),
    .w_valid_i    (w_head_valid),
    .w_i          (w_head),
    .ar_valid_i   (ar_head_valid),
    .ar_i         (ar_head),
    .mgr_bready_i (mgr_bready),
    .mgr_rready_i (mgr_rready),
    .route_i      (route),
    .sub_resp_i   (sub_resp_i),
    .aw_pop_o     (aw_pop),
    .w_pop_o      (w_pop),
    .ar_pop_o     (ar_pop),
    .sub_req_o    (sub_req_o),
    .mgr_b_o      (mgr_b),
    .mgr_bvalid_o (mgr_bvalid),
    .mgr_r_o      (mgr_r),
    .mgr_rvalid_o (mgr_rvalid),
    .evt_o        (evt),
    .aw_pending_o (aw_pending),
    .w_pending_o  (w_pending),
    .ar_pending_o (ar_pending)
  );

endmodule

// File: bench/tb_clk_gen.sv
// 10 ns clock; reset is held low for the first 8 rising edges and released on an edge
module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    repeat (8) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

// File: bench/tb_cfg_subsys.sv
// Subordinates are modelled here; manager 0 uses even words and manager 1 odd words
module tb_cfg_subsys
  import cfg_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumTxn      = 125;
  localparam int WatchCycles = NumTxn * (RespTimeout + 32) + 20;

  typedef struct {
    bit      wr;
    int      m;
    r_chan_t exp;
    r_chan_t got;
  } res_t;

  logic                    clk, arst_n;
  lite_req_t [NumMgr-1:0]  mgr_req;
  lite_resp_t [NumMgr-1:0] mgr_resp;
  lite_req_t [NumSub-1:0]  sub_req;
  lite_resp_t [NumSub-1:0] sub_resp;

  data_t shadow [4096];
  data_t sub_mem [NumSub][4096];
  int    req_cnt [NumSub];
  bit    sub_mute [NumSub];
  bit    dly_en;
  int    errors;
  int    test_base;
  res_t  res_q[$];

  tb_clk_gen i_clk (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  cfg_lite_subsystem DUT (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .mgr_req_i  (mgr_req),
    .mgr_resp_o (mgr_resp),
    .sub_req_o  (sub_req),
    .sub_resp_i (sub_resp)
  );

  // Every word starts from a value tied to its full bus address
  function automatic data_t init_word(int idx);
    return (32'h1040_0000 + 32'(idx) * 4) ^ 32'hC3C3_0000;
  endfunction

  // Expected response from the address map and the shadow memory
  function automatic r_chan_t ref_access(bit wr, addr_t a, data_t d, strb_t s);
    r_chan_t exp;
    int      sub;
    sub = -1;
    if (a >= 32'h1040_0000 && a < 32'h1040_1000) sub = 0;
    else if (a >= 32'h1040_1000 && a < 32'h1040_3000) sub = 1;
    else if (a >= 32'h1040_3000 && a < 32'h1040_4000) sub = 2;
    exp.data = '0;
    if (sub < 0) begin
      exp.resp = RESP_DECERR;
    end else if (sub_mute[sub]) begin
      exp.resp = RESP_SLVERR;
    end else begin
      exp.resp = RESP_OKAY;
      for (int b = 0; b < 4; b++) begin
        if (wr && s[b]) shadow[a[13:2]][8*b +: 8] = d[8*b +: 8];
      end
      if (!wr) exp.data = shadow[a[13:2]];
    end
    return exp;
  endfunction

  function automatic addr_t rand_addr(int region, int m);
    return 32'h1040_0000 + 32'(region) * 32'h1000 + 32'((($urandom % 512) * 2 + m) * 4);
  endfunction

  task automatic check_b(string name, b_chan_t got, b_chan_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_r(string name, r_chan_t got, r_chan_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // Register-memory subordinate; readies drop while a response is owed
  task automatic sub_model(int s);
    bit      aw_got, w_got, b_pend, r_pend, aw_f, w_f, ar_f, b_f, r_f, rnd;
    addr_t   wa;
    w_chan_t wd;
    data_t   rd;
    aw_got = 0;
    w_got  = 0;
    b_pend = 0;
    r_pend = 0;
    wait (arst_n);
    forever begin
      @(negedge clk);
      aw_f = sub_req[s].aw_valid && sub_resp[s].aw_ready;
      w_f  = sub_req[s].w_valid && sub_resp[s].w_ready;
      ar_f = sub_req[s].ar_valid && sub_resp[s].ar_ready;
      b_f  = sub_resp[s].b_valid && sub_req[s].b_ready;
      r_f  = sub_resp[s].r_valid && sub_req[s].r_ready;
      if (aw_f) begin
        aw_got = 1;
        wa     = sub_req[s].aw.addr;
        req_cnt[s]++;
      end
      if (w_f) begin
        w_got = 1;
        wd    = sub_req[s].w;
      end
      if (ar_f) begin
        req_cnt[s]++;
        rd = sub_mem[s][sub_req[s].ar.addr[13:2]];
      end
      if (b_f) b_pend = 0;
      if (r_f) r_pend = 0;
      @(posedge clk);
      if (b_f) sub_resp[s].b_valid <= 1'b0;
      if (r_f) sub_resp[s].r_valid <= 1'b0;
      if (aw_got && w_got) begin
        for (int b = 0; b < 4; b++) begin
          if (wd.strb[b]) sub_mem[s][wa[13:2]][8*b +: 8] = wd.data[8*b +: 8];
        end
        aw_got = 0;
        w_got  = 0;
        if (!sub_mute[s]) begin
          b_pend = 1;
          sub_resp[s].b_valid <= 1'b1;
          sub_resp[s].b.resp  <= RESP_OKAY;
        end
      end
      if (ar_f && !sub_mute[s]) begin
        r_pend = 1;
        sub_resp[s].r_valid <= 1'b1;
        sub_resp[s].r.data  <= rd;
        sub_resp[s].r.resp  <= RESP_OKAY;
      end
      rnd = !dly_en || ($urandom % 4 != 0);
      sub_resp[s].aw_ready <= !aw_got && !b_pend && rnd;
      sub_resp[s].w_ready  <= !w_got && !b_pend && rnd;
      sub_resp[s].ar_ready <= !r_pend && rnd;
    end
  endtask

  // One complete access from manager m; stall makes the response ready random
  task automatic do_access(int m, bit wr, addr_t a, data_t d, strb_t s, bit stall,
                           output r_chan_t got);
    bit      aw_left, w_left, ar_left, aw_hs, w_hs, ar_hs;
    bit      done, held, vld, rdy, rnd;
    r_chan_t now_rsp, held_rsp;
    @(posedge clk);
    aw_left = wr;
    w_left  = wr;
    ar_left = !wr;
    mgr_req[m].aw_valid <= wr;
    mgr_req[m].aw.addr  <= a;
    mgr_req[m].w_valid  <= wr;
    mgr_req[m].w.data   <= d;
    mgr_req[m].w.strb   <= s;
    mgr_req[m].ar_valid <= !wr;
    mgr_req[m].ar.addr  <= a;
    mgr_req[m].b_ready  <= wr && !stall;
    mgr_req[m].r_ready  <= !wr && !stall;
    while (aw_left || w_left || ar_left) begin
      @(negedge clk);
      aw_hs = aw_left && mgr_resp[m].aw_ready;
      w_hs  = w_left && mgr_resp[m].w_ready;
      ar_hs = ar_left && mgr_resp[m].ar_ready;
      @(posedge clk);
      if (aw_hs) begin
        aw_left = 0;
        mgr_req[m].aw_valid <= 1'b0;
      end
      if (w_hs) begin
        w_left = 0;
        mgr_req[m].w_valid <= 1'b0;
      end
      if (ar_hs) begin
        ar_left = 0;
        mgr_req[m].ar_valid <= 1'b0;
      end
    end
    done = 0;
    held = 0;
    held_rsp = '0;
    while (!done) begin
      @(negedge clk);
      vld = wr ? mgr_resp[m].b_valid : mgr_resp[m].r_valid;
      rdy = wr ? mgr_req[m].b_ready : mgr_req[m].r_ready;
      now_rsp = mgr_resp[m].r;
      if (wr) begin
        now_rsp.data = '0;
        now_rsp.resp = mgr_resp[m].b.resp;
      end
      if (held && (!vld || now_rsp !== held_rsp)) begin
        $display("Manager %0d response dropped or changed while ready was low", m);
        errors++;
      end
      done     = vld && rdy;
      held     = vld && !rdy;
      held_rsp = now_rsp;
      @(posedge clk);
      rnd = !stall || ($urandom % 3 == 0);
      mgr_req[m].b_ready <= wr && !done && rnd;
      mgr_req[m].r_ready <= !wr && !done && rnd;
    end
    got = held_rsp;
  endtask

  task automatic issue(int m, bit wr, addr_t a, bit stall);
    data_t   d;
    strb_t   s;
    r_chan_t exp;
    r_chan_t got;
    res_t    e;
    d   = $urandom;
    s   = wr ? strb_t'($urandom) : '0;
    exp = ref_access(wr, a, d, s);
    do_access(m, wr, a, d, s, stall, got);
    e.wr  = wr;
    e.m   = m;
    e.exp = exp;
    e.got = got;
    res_q.push_back(e);
  endtask

  task automatic end_test(string name);
    repeat (2) @(negedge clk);
    $display("test %-12s %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  task automatic check_quiet();
    for (int s = 0; s < NumSub; s++) begin
      if (sub_req[s].aw_valid || sub_req[s].w_valid || sub_req[s].ar_valid) begin
        $display("Subordinate %0d request valid raised around reset", s);
        errors++;
      end
    end
    for (int m = 0; m < NumMgr; m++) begin
      if (mgr_resp[m].b_valid || mgr_resp[m].r_valid) begin
        $display("Manager %0d response valid raised around reset", m);
        errors++;
      end
    end
  endtask

  // Compares every finished access against its expected value
  initial begin
    res_t e;
    forever begin
      @(negedge clk);
      while (res_q.size() > 0) begin
        e = res_q.pop_front();
        if (e.wr) begin
          check_b($sformatf("mgr_resp_o[%0d].b", e.m), b_chan_t'(e.got.resp),
                  b_chan_t'(e.exp.resp));
        end else begin
          check_r($sformatf("mgr_resp_o[%0d].r", e.m), e.got, e.exp);
        end
      end
    end
  end

  initial begin
    repeat (WatchCycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", WatchCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int snap;
    int done_cnt [NumMgr];
    int other_done [NumMgr];
    mgr_req   = '0;
    sub_resp  = '0;
    errors    = 0;
    test_base = 0;
    dly_en    = 0;
    void'($urandom(32'he5c74575));
    for (int i = 0; i < 4096; i++) begin
      shadow[i] = init_word(i);
      for (int s = 0; s < NumSub; s++) sub_mem[s][i] = init_word(i);
    end
    for (int s = 0; s < NumSub; s++) begin
      req_cnt[s]  = 0;
      sub_mute[s] = 0;
    end
    fork
      sub_model(0);
      sub_model(1);
      sub_model(2);
    join_none

    while (arst_n !== 1'b1) begin
      @(negedge clk);
      check_quiet();
    end
    repeat (2) begin
      @(negedge clk);
      check_quiet();
    end
    end_test("reset");

    dly_en = 1;
    for (int m = 0; m < NumMgr; m++) begin
      for (int r = 0; r < 4; r++) begin
        repeat (4) begin
          addr_t a;
          a = rand_addr(r, m);
          issue(m, 1, a, 0);
          issue(m, 0, a, 0);
        end
      end
    end
    end_test("readback");

    snap = req_cnt[0] + req_cnt[1] + req_cnt[2];
    for (int m = 0; m < NumMgr; m++) begin
      issue(m, 1, 32'h1040_4000, 0);
      issue(m, 0, 32'h1040_4000, 0);
      issue(m, 1, 32'h0000_0100, 0);
      issue(m, 0, 32'h0000_0100, 0);
    end
    if (req_cnt[0] + req_cnt[1] + req_cnt[2] != snap) begin
      $display("A subordinate received a request for an unmapped address");
      errors++;
    end
    end_test("decerr");

    for (int m = 0; m < NumMgr; m++) begin
      done_cnt[m]   = 0;
      other_done[m] = 0;
    end
    // Each manager notes how far the other got when its own last access completed
    fork
      begin
        for (int k = 0; k < 16; k++) begin
          issue(0, 1'($urandom % 2), rand_addr($urandom % 4, 0), 0);
          done_cnt[0] = k + 1;
        end
        other_done[0] = done_cnt[1];
      end
      begin
        for (int k = 0; k < 16; k++) begin
          issue(1, 1'($urandom % 2), rand_addr($urandom % 4, 1), 0);
          done_cnt[1] = k + 1;
        end
        other_done[1] = done_cnt[0];
      end
    join
    if (other_done[0] < 8 || other_done[1] < 8) begin
      $display("A manager was starved while the other finished its concurrent accesses");
      errors++;
    end
    end_test("concurrent");

    dly_en      = 0;
    sub_mute[2] = 1;
    issue(0, 1, 32'h1040_3010, 0);
    snap = req_cnt[2];
    issue(1, 0, 32'h1040_3020, 0);
    issue(0, 1, 32'h1040_3030, 0);
    if (req_cnt[2] != snap) begin
      $display("Subordinate 2 received a request after it timed out");
      errors++;
    end
    issue(0, 0, rand_addr(0, 0), 0);
    issue(1, 1, rand_addr(2, 1), 0);
    end_test("timeout");

    dly_en = 1;
    fork
      for (int k = 0; k < 8; k++) issue(0, 1'($urandom % 2), rand_addr($urandom % 3, 0), 1);
      for (int k = 0; k < 8; k++) issue(1, 1'($urandom % 2), rand_addr($urandom % 3, 1), 1);
    join
    end_test("backpressure");

    $display("checks done: %0d errors", errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
src/cfg_pkg.sv
src/cfg_chan_reg.sv
src/cfg_resp_timer.sv
src/cfg_xbar_fsm.sv
src/cfg_route_mux.sv
src/cfg_lite_subsystem.sv
bench/tb_clk_gen.sv
bench/tb_cfg_subsys.sv

// File: run.sh
#!/bin/sh
# Build and run the config subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_cfg_subsys \
  --Mdir obj_dir \
  -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
else
  exit 1
fi
